// File: dcache_pkg.sv
`default_nettype none

package dcache_pkg;

  // bus widths
  localparam int ADDR_W = 32;
  localparam int XLEN   = 64;
  localparam int LINE_W = 128;  // two 64-bit beats

  // address split: tag | index | offset
  localparam int OFFSET_W = 4;   // 16-byte lines
  localparam int INDEX_W  = 5;   // 32 lines
  localparam int TAG_W    = 23;

  // any address carrying these bits bypasses the cache
  localparam logic [ADDR_W-1:0] MMIO_BASE = 32'h8000_0000;

  // load/store request from the CPU
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [7:0]        mask;   // byte lanes within the 64-bit beat
    logic [3:0]        size;   // one-hot 1/2/4/8 bytes
    logic              write;
    logic [XLEN-1:0]   wdata;  // lane aligned, same as mask
  } cpu_req_t;

  // memory read request, len is beats minus one
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [7:0]        mask;
    logic [3:0]        size;
    logic [7:0]        len;
  } mem_rreq_t;

  // memory write request, always a single beat
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [7:0]        mask;
    logic [3:0]        size;
    logic [XLEN-1:0]   wdata;
  } mem_wreq_t;

  // one cache line, seen per beat for refill and store merge,
  // or per byte for load extraction
  typedef union packed {
    logic [1:0][XLEN-1:0] beats;
    logic [15:0][7:0]     bytes;
  } cache_line_u;

endpackage

`default_nettype wire

// File: dcache_tag.sv
`default_nettype none

module dcache_tag (
  input  wire                            clk,
  input  wire                            rst,
  input  wire [dcache_pkg::INDEX_W-1:0]  index_i,
  input  wire [dcache_pkg::TAG_W-1:0]    tag_i,
  input  wire                            wen_i,   // fill done, install tag
  output logic                           hit_o
);

  localparam int LINES = 2 ** dcache_pkg::INDEX_W;

  logic [LINES-1:0]             valid_q;
  logic [dcache_pkg::TAG_W-1:0] tags_q [LINES];

  // valid bits are the only control state here
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (wen_i) begin
      valid_q[index_i] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wen_i) begin
      tags_q[index_i] <= tag_i;
    end
  end

  assign hit_o = valid_q[index_i] && (tags_q[index_i] == tag_i);  // same-cycle lookup

endmodule

`default_nettype wire

// File: dcache_data.sv
`default_nettype none

module dcache_data (
  input  wire                             clk,
  input  wire [dcache_pkg::INDEX_W-1:0]   index_i,
  input  dcache_pkg::cache_line_u         wdata_i,
  input  wire [dcache_pkg::LINE_W-1:0]    wmask_i,  // one bit per data bit
  input  wire                             wen_i,
  output dcache_pkg::cache_line_u         rdata_o
);

  localparam int LINES = 2 ** dcache_pkg::INDEX_W;

  logic [dcache_pkg::LINE_W-1:0] lines_q [LINES];

  // masked write, so a refill beat or a partial store touches
  // only its own bits of the line
  always_ff @(posedge clk) begin
    if (wen_i) begin
      lines_q[index_i] <= (lines_q[index_i] & ~wmask_i) | (wdata_i & wmask_i);
    end
  end

  // asynchronous read, load data follows the index in the same cycle
  assign rdata_o = lines_q[index_i];

endmodule

`default_nettype wire

// File: dcache_top.sv
`default_nettype none

module dcache_top (
  input  wire                           clk,
  input  wire                           rst,
  // CPU port
  input  dcache_pkg::cpu_req_t          req_i,
  input  wire                           req_valid_i,
  output logic [dcache_pkg::XLEN-1:0]   rdata_o,
  output logic                          data_ready_o,
  // memory read channel
  output dcache_pkg::mem_rreq_t         mem_rreq_o,
  output logic                          mem_rvalid_o,
  input  wire                           mem_rready_i,
  input  wire  [dcache_pkg::XLEN-1:0]   mem_rdata_i,
  // memory write channel
  output dcache_pkg::mem_wreq_t         mem_wreq_o,
  output logic                          mem_wvalid_o,
  input  wire                           mem_wready_i
);

  localparam logic [1:0] S_IDLE     = 2'd0;
  localparam logic [1:0] S_RD_MISS  = 2'd1;
  localparam logic [1:0] S_WR_THRU  = 2'd2;
  localparam logic [1:0] S_UNCACHED = 2'd3;

  localparam int XLEN = dcache_pkg::XLEN;

  logic [1:0]                     state;
  logic                           ready_q;    // one-cycle completion pulse
  logic                           tag_wen_q;  // blocked cycle after refill
  logic                           merge_q;    // blocked cycle for store merge
  logic [0:0]                     beat_cnt;
  logic [XLEN-1:0]                unc_beat_q;
  dcache_pkg::mem_rreq_t          rreq_q;
  dcache_pkg::mem_wreq_t          wreq_q;

  logic                           uncached;
  logic [dcache_pkg::INDEX_W-1:0] index;
  logic [dcache_pkg::TAG_W-1:0]   tag;
  logic                           hit;
  logic                           accept;
  logic                           rd_hs;
  logic                           wr_hs;
  logic                           data_wen;
  logic [XLEN-1:0]                store_mask;
  logic [dcache_pkg::LINE_W-1:0]  line_wmask;
  dcache_pkg::cache_line_u        line_wdata;
  dcache_pkg::cache_line_u        line_rdata;
  dcache_pkg::cache_line_u        src_line;
  logic [XLEN-1:0]                shifted;

  assign uncached = (req_i.addr & dcache_pkg::MMIO_BASE) == dcache_pkg::MMIO_BASE;
  assign index    = req_i.addr[dcache_pkg::OFFSET_W +: dcache_pkg::INDEX_W];
  assign tag      = req_i.addr[dcache_pkg::OFFSET_W + dcache_pkg::INDEX_W +: dcache_pkg::TAG_W];

  // no new request while the arrays update or a response is out
  assign accept = (state == S_IDLE) && req_valid_i && !ready_q && !tag_wen_q;
  assign rd_hs  = mem_rvalid_o && mem_rready_i;
  assign wr_hs  = mem_wvalid_o && mem_wready_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= S_IDLE;
      mem_rvalid_o <= 1'b0;
      mem_wvalid_o <= 1'b0;
      ready_q      <= 1'b0;
      tag_wen_q    <= 1'b0;
      merge_q      <= 1'b0;
      beat_cnt     <= '0;
    end else begin
      ready_q   <= 1'b0;
      tag_wen_q <= 1'b0;
      merge_q   <= 1'b0;
      case (state)
        S_IDLE: begin
          if (accept) begin
            if (uncached) begin
              state <= S_UNCACHED;
              if (req_i.write) begin
                mem_wvalid_o <= 1'b1;
              end else begin
                mem_rvalid_o <= 1'b1;
              end
            end else if (req_i.write) begin
              state        <= S_WR_THRU;  // write through, no allocate
              mem_wvalid_o <= 1'b1;
              merge_q      <= hit;
            end else if (hit) begin
              ready_q <= 1'b1;
            end else begin
              state        <= S_RD_MISS;
              mem_rvalid_o <= 1'b1;
              beat_cnt     <= '0;
            end
          end
        end
        S_RD_MISS: begin
          if (rd_hs) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (beat_cnt == 1'b1) begin  // last beat of the line
              mem_rvalid_o <= 1'b0;
              tag_wen_q    <= 1'b1;
              state        <= S_IDLE;   // replays as a hit
            end
          end
        end
        S_WR_THRU: begin
          if (wr_hs) begin
            mem_wvalid_o <= 1'b0;
            ready_q      <= 1'b1;
            state        <= S_IDLE;
          end
        end
        default: begin  // uncached, one beat either way
          if (rd_hs || wr_hs) begin
            mem_rvalid_o <= 1'b0;
            mem_wvalid_o <= 1'b0;
            ready_q      <= 1'b1;
            state        <= S_IDLE;
          end
        end
      endcase
    end
  end

  // request payloads, captured once at accept and held until ready
  always_ff @(posedge clk) begin
    if (accept) begin
      if (!uncached && !req_i.write) begin
        rreq_q.addr <= {req_i.addr[dcache_pkg::ADDR_W-1:dcache_pkg::OFFSET_W],
                        {dcache_pkg::OFFSET_W{1'b0}}};  // line aligned
        rreq_q.mask <= 8'hff;
        rreq_q.size <= 4'b1000;
        rreq_q.len  <= 8'd1;
      end else begin
        rreq_q.addr <= req_i.addr;
        rreq_q.mask <= req_i.mask;
        rreq_q.size <= req_i.size;
        rreq_q.len  <= 8'd0;
      end
      wreq_q.addr  <= req_i.addr;
      wreq_q.mask  <= req_i.mask;
      wreq_q.size  <= req_i.size;
      wreq_q.wdata <= req_i.wdata;
    end
    if (state == S_UNCACHED && rd_hs) begin
      unc_beat_q <= mem_rdata_i;
    end
  end

  assign mem_rreq_o = rreq_q;
  assign mem_wreq_o = wreq_q;

  // byte mask expanded to bits
  always_comb begin
    for (int b = 0; b < 8; b++) begin
      store_mask[b*8 +: 8] = {8{req_i.mask[b]}};
    end
  end

  // refill beats and store merges share the one array port
  always_comb begin
    line_wdata = '0;
    line_wmask = '0;
    if (state == S_RD_MISS) begin
      line_wdata.beats[beat_cnt]        = mem_rdata_i;
      line_wmask[beat_cnt*XLEN +: XLEN] = '1;
    end else begin
      line_wdata.beats[req_i.addr[3]]        = req_i.wdata;
      line_wmask[req_i.addr[3]*XLEN +: XLEN] = store_mask;
    end
  end

  assign data_wen = (state == S_RD_MISS && rd_hs) || merge_q;

  dcache_tag u_tag (
    .clk     (clk),
    .rst     (rst),
    .index_i (index),
    .tag_i   (tag),
    .wen_i   (tag_wen_q),
    .hit_o   (hit)
  );

  dcache_data u_data (
    .clk     (clk),
    .index_i (index),
    .wdata_i (line_wdata),
    .wmask_i (line_wmask),
    .wen_i   (data_wen),
    .rdata_o (line_rdata)
  );

  // load data: uncached beat is mirrored so the same offset works
  always_comb begin
    src_line = line_rdata;
    if (uncached) begin
      src_line.beats = {unc_beat_q, unc_beat_q};
    end
    for (int k = 0; k < 8; k++) begin
      shifted[k*8 +: 8] = src_line.bytes[req_i.addr[3:0] + 4'(k)];
    end
    if (req_i.size[0]) begin
      rdata_o = {{(XLEN-8){1'b0}}, shifted[7:0]};
    end else if (req_i.size[1]) begin
      rdata_o = {{(XLEN-16){1'b0}}, shifted[15:0]};
    end else if (req_i.size[2]) begin
      rdata_o = {{(XLEN-32){1'b0}}, shifted[31:0]};
    end else begin
      rdata_o = shifted;
    end
  end

  assign data_ready_o = ready_q;

  // read and write channels never busy at once
  a_one_channel: assert property (@(posedge clk) disable iff (rst)
    !(mem_rvalid_o && mem_wvalid_o));

  // every completion lands back in idle
  a_ready_idle: assert property (@(posedge clk) disable iff (rst)
    data_ready_o |-> state == S_IDLE);

  // CPU must hold its request for the whole transfer
  a_req_stable: assert property (@(posedge clk) disable iff (rst)
    (state != S_IDLE) |=> req_valid_i && $stable(req_i));

endmodule

`default_nettype wire

// File: mem_ram.sv
`default_nettype none

module mem_ram #(
  parameter int MEM_WORDS   = 128,
  parameter int MEM_LATENCY = 3
) (
  input  wire                          clk,
  input  wire                          rst,
  input  dcache_pkg::mem_rreq_t        rreq_i,
  input  wire                          rvalid_i,
  output logic                         rready_o,
  output logic [dcache_pkg::XLEN-1:0]  rdata_o,
  input  dcache_pkg::mem_wreq_t        wreq_i,
  input  wire                          wvalid_i,
  output logic                         wready_o
);

  localparam int AW = $clog2(MEM_WORDS);
  localparam int LW = $clog2(MEM_LATENCY + 1);

  logic [dcache_pkg::XLEN-1:0] mem [MEM_WORDS];
  logic [LW-1:0]               lat_cnt;
  logic [7:0]                  r_beat;
  logic [AW-1:0]               rd_word;
  logic [AW-1:0]               wr_word;
  logic                        rd_hs;

  // upper address bits dropped, uncached addresses alias
  assign rd_word = rreq_i.addr[3 +: AW] + AW'(r_beat);
  assign wr_word = wreq_i.addr[3 +: AW];
  assign rd_hs   = rvalid_i && rready_o;
  assign rdata_o = mem[rd_word];

  always_ff @(posedge clk) begin
    if (rst) begin
      lat_cnt  <= '0;
      r_beat   <= '0;
      rready_o <= 1'b0;
      wready_o <= 1'b0;
    end else begin
      wready_o <= 1'b0;  // single-beat write, ready is a pulse
      if (rd_hs) begin
        if (r_beat == rreq_i.len) begin
          rready_o <= 1'b0;
          r_beat   <= '0;
        end else begin
          r_beat <= r_beat + 8'd1;  // next beat right away
        end
      end else if ((rvalid_i || wvalid_i) && !rready_o && !wready_o) begin
        if (lat_cnt == LW'(MEM_LATENCY - 1)) begin
          lat_cnt <= '0;
          if (rvalid_i) begin
            rready_o <= 1'b1;
          end else begin
            wready_o <= 1'b1;
          end
        end else begin
          lat_cnt <= lat_cnt + 1'b1;
        end
      end
    end
  end

  // byte-masked write
  always_ff @(posedge clk) begin
    if (wvalid_i && wready_o) begin
      for (int b = 0; b < 8; b++) begin
        if (wreq_i.mask[b]) begin
          mem[wr_word][b*8 +: 8] <= wreq_i.wdata[b*8 +: 8];
        end
      end
    end
  end

  // every beat handed out lies within the requested len
  a_no_extra_beat: assert property (@(posedge clk) disable iff (rst)
    rd_hs |-> r_beat <= rreq_i.len);

endmodule

`default_nettype wire

// File: mem_subsys_top.sv
`default_nettype none

module mem_subsys_top #(
  parameter int MEM_WORDS   = 128,  // 1 KiB, twice the cache
  parameter int MEM_LATENCY = 3
) (
  input  wire                          clk,
  input  wire                          rst,
  input  dcache_pkg::cpu_req_t         req_i,
  input  wire                          req_valid_i,
  output logic [dcache_pkg::XLEN-1:0]  rdata_o,
  output logic                         data_ready_o
);

  dcache_pkg::mem_rreq_t        rreq;
  dcache_pkg::mem_wreq_t        wreq;
  logic                         rvalid;
  logic                         rready;
  logic                         wvalid;
  logic                         wready;
  logic [dcache_pkg::XLEN-1:0]  rdata;

  dcache_top u_dcache (
    .clk          (clk),
    .rst          (rst),
    .req_i        (req_i),
    .req_valid_i  (req_valid_i),
    .rdata_o      (rdata_o),
    .data_ready_o (data_ready_o),
    .mem_rreq_o   (rreq),
    .mem_rvalid_o (rvalid),
    .mem_rready_i (rready),
    .mem_rdata_i  (rdata),
    .mem_wreq_o   (wreq),
    .mem_wvalid_o (wvalid),
    .mem_wready_i (wready)
  );

  mem_ram #(
    .MEM_WORDS   (MEM_WORDS),
    .MEM_LATENCY (MEM_LATENCY)
  ) u_ram (
    .clk      (clk),
    .rst      (rst),
    .rreq_i   (rreq),
    .rvalid_i (rvalid),
    .rready_o (rready),
    .rdata_o  (rdata),
    .wreq_i   (wreq),
    .wvalid_i (wvalid),
    .wready_o (wready)
  );

endmodule

`default_nettype wire

// File: tb_clkgen.sv
`default_nettype none

module tb_clkgen (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;  // period 100
  end

  // reset held over the first 4 rising edges
  initial begin
    rst_o = 1'b1;
    repeat (4) @(posedge clk_o);
    #10 rst_o = 1'b0;
  end

endmodule

`default_nettype wire

// File: tb_top.sv
`default_nettype none

module tb_top;

  localparam int MEM_WORDS      = 128;
  localparam int MEM_LATENCY    = 3;
  localparam int AW             = $clog2(MEM_WORDS);
  localparam int LINES          = 2 ** dcache_pkg::INDEX_W;
  localparam int ACCESS_TIMEOUT = 200;
  localparam int N_RANDOM       = 400;
  localparam int CYCLE_LIMIT    = 1000 * 20;  // ~840 accesses, well under 20 cycles each

  logic                         clk;
  logic                         rst;
  dcache_pkg::cpu_req_t         req;
  logic                         req_valid;
  logic [dcache_pkg::XLEN-1:0]  rdata;
  logic                         data_ready;

  // expected state: RAM image and the cache as it should be
  logic [63:0]                  shadow_mem [MEM_WORDS];
  logic                         line_valid [LINES];
  logic [dcache_pkg::TAG_W-1:0] line_tag   [LINES];
  logic [127:0]                 line_data  [LINES];

  logic [63:0] exp_q [$];  // one entry per issued access
  logic        rd_q  [$];
  logic [63:0] exp_data;
  logic        was_read;
  int unsigned resp_cnt   = 0;
  int unsigned data_errs  = 0;
  int unsigned other_errs = 0;
  int unsigned cycle_cnt  = 0;
  logic        stim_done  = 1'b0;
  logic        hung       = 1'b0;

  tb_clkgen u_clkgen (
    .clk_o (clk),
    .rst_o (rst)
  );

  mem_subsys_top #(
    .MEM_WORDS   (MEM_WORDS),
    .MEM_LATENCY (MEM_LATENCY)
  ) u_dut (
    .clk          (clk),
    .rst          (rst),
    .req_i        (req),
    .req_valid_i  (req_valid),
    .rdata_o      (rdata),
    .data_ready_o (data_ready)
  );

  // pattern built from the whole address
  function automatic logic [63:0] fill_value(input logic [31:0] a);
    return {a ^ 32'h5a5a_0000, ~a};
  endfunction

  function automatic logic [7:0] lane_mask(input logic [2:0] off, input logic [3:0] size);
    logic [7:0] m;
    m = 8'((16'd1 << size) - 16'd1);  // size code equals byte count
    return m << off;
  endfunction

  // aligned byte offset for an access of 2**k bytes
  function automatic logic [2:0] rand_off(input int k);
    return 3'(($urandom % (8 >> k)) << k);
  endfunction

  // cached read whose line the expected cache already holds
  function automatic logic cached_read_hit(input dcache_pkg::cpu_req_t r);
    logic [dcache_pkg::INDEX_W-1:0] idx;
    logic [dcache_pkg::TAG_W-1:0]   tg;
    idx = r.addr[dcache_pkg::OFFSET_W +: dcache_pkg::INDEX_W];
    tg  = r.addr[dcache_pkg::ADDR_W-1 -: dcache_pkg::TAG_W];
    return !r.write && ((r.addr & dcache_pkg::MMIO_BASE) != dcache_pkg::MMIO_BASE)
           && line_valid[idx] && (line_tag[idx] == tg);
  endfunction

  function automatic logic [63:0] ref_access(input dcache_pkg::cpu_req_t r);
    logic [AW-1:0]                  word;
    logic [dcache_pkg::INDEX_W-1:0] idx;
    logic [dcache_pkg::TAG_W-1:0]   tg;
    logic [63:0]                    bits;
    logic [63:0]                    beat;
    logic                           hit;
    word = r.addr[3 +: AW];  // RAM drops the upper bits
    idx  = r.addr[dcache_pkg::OFFSET_W +: dcache_pkg::INDEX_W];
    tg   = r.addr[dcache_pkg::ADDR_W-1 -: dcache_pkg::TAG_W];
    hit  = line_valid[idx] && (line_tag[idx] == tg);
    for (int b = 0; b < 8; b++) begin
      bits[b*8 +: 8] = {8{r.mask[b]}};
    end
    if ((r.addr & dcache_pkg::MMIO_BASE) == dcache_pkg::MMIO_BASE) begin
      beat = shadow_mem[word];  // cache left alone
      if (r.write) begin
        shadow_mem[word] = (beat & ~bits) | (r.wdata & bits);
      end
    end else if (r.write) begin
      shadow_mem[word] = (shadow_mem[word] & ~bits) | (r.wdata & bits);
      if (hit) begin
        beat = line_data[idx][r.addr[3]*64 +: 64];
        line_data[idx][r.addr[3]*64 +: 64] = (beat & ~bits) | (r.wdata & bits);
      end
    end else begin
      if (!hit) begin  // refill the whole line
        line_valid[idx] = 1'b1;
        line_tag[idx]   = tg;
        line_data[idx]  = {shadow_mem[{word[AW-1:1], 1'b1}],
                           shadow_mem[{word[AW-1:1], 1'b0}]};
      end
      beat = line_data[idx][r.addr[3]*64 +: 64];
    end
    if (r.write) begin
      return '0;
    end
    beat = beat >> (8 * r.addr[2:0]);
    case (r.size)
      4'b0001: return {56'b0, beat[7:0]};
      4'b0010: return {48'b0, beat[15:0]};
      4'b0100: return {32'b0, beat[31:0]};
      default: return beat;
    endcase
  endfunction

  task automatic access(input logic [31:0] addr, input logic [3:0] size,
                        input logic wr, input logic [63:0] data);
    dcache_pkg::cpu_req_t r;
    int unsigned          seen;
    int                   waited;
    logic                 exp_hit;
    r.addr  = addr;
    r.size  = size;
    r.write = wr;
    r.mask  = lane_mask(addr[2:0], size);
    r.wdata = data << (8 * addr[2:0]);  // lane aligned
    exp_hit = cached_read_hit(r);
    exp_q.push_back(ref_access(r));
    rd_q.push_back(!wr);
    seen      = resp_cnt;
    waited    = 0;
    req       = r;
    req_valid = 1'b1;
    while (resp_cnt == seen && waited < ACCESS_TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    assert (resp_cnt != seen) else begin
      $display("no response from the DUT within %0d cycles for address %h",
               ACCESS_TIMEOUT, addr);
      other_errs++;
      hung = 1'b1;
      forever @(posedge clk);  // parked until the run ends
    end
    // a hit answers one cycle after the request is seen, anything else later
    assert ((waited == 2) == exp_hit) else begin
      $display("access to address %h answered %0d cycles after it was seen, hit expected %0b",
               addr, waited - 1, exp_hit);
      other_errs++;
    end
    #10;
  endtask

  initial begin : stimulus
    logic [31:0] a;
    logic [2:0]  off;
    int          k;
    req       = '0;
    req_valid = 1'b0;
    for (int i = 0; i < LINES; i++) begin
      line_valid[i] = 1'b0;
    end
    void'($urandom(32'h6a5b_ae08));
    wait (!rst);

    // fill, every write misses and does not allocate
    for (int w = 0; w < MEM_WORDS; w++) begin
      a = 32'(w) << 3;
      access(a, 4'd8, 1'b1, fill_value(a));
    end
    for (int w = 0; w < MEM_WORDS; w++) begin
      access(32'(w) << 3, 4'd8, 1'b0, '0);
    end

    // 512 bytes apart, same index
    for (int i = 0; i < 8; i++) begin
      a = (32'(i) << 5) | 32'h8;
      for (int j = 0; j < 2; j++) begin
        access(a, 4'd8, 1'b0, '0);
        access(a + 32'h200, 4'd8, 1'b0, '0);
      end
    end

    // partial stores into cached lines
    for (int i = 0; i < 32; i++) begin
      a   = ($urandom % MEM_WORDS) << 3;
      k   = int'($urandom % 3);
      off = rand_off(k);
      access(a, 4'd8, 1'b0, '0);
      access(a | 32'(off), 4'(1 << k), 1'b1, {$urandom, $urandom});
      access(a, 4'd8, 1'b0, '0);
      access(a | dcache_pkg::MMIO_BASE, 4'd8, 1'b0, '0);  // RAM side of the merge
    end

    // sub-word loads
    for (int i = 0; i < 4; i++) begin
      a = ($urandom % MEM_WORDS) << 3;
      for (k = 0; k < 4; k++) begin
        access(a | 32'(rand_off(k)), 4'(1 << k), 1'b0, '0);
      end
    end

    // uncached alias of a cached word
    for (int i = 0; i < 2; i++) begin
      a = 32'h40 + (32'(i) << 9);
      access(a, 4'd8, 1'b0, '0);
      access(a | dcache_pkg::MMIO_BASE, 4'd8, 1'b1, ~fill_value(a));
      access(a | dcache_pkg::MMIO_BASE, 4'd8, 1'b0, '0);
      access(a, 4'd8, 1'b0, '0);  // stale line still hits
    end

    for (int i = 0; i < N_RANDOM; i++) begin
      k = int'($urandom % 4);
      a = (($urandom % MEM_WORDS) << 3) | 32'(rand_off(k));
      if ($urandom % 8 == 0) begin
        a = a | dcache_pkg::MMIO_BASE;
      end
      access(a, 4'(1 << k), ($urandom % 3) == 0, {$urandom, $urandom});
    end
    req_valid = 1'b0;
    stim_done = 1'b1;
  end

  // responses checked mid-cycle, away from the driving edge
  always @(negedge clk) begin
    if (!rst && data_ready) begin
      assert (exp_q.size() > 0) else begin
        $display("DUT signalled data ready at time %0t with no access pending", $time);
        other_errs++;
      end
      if (exp_q.size() > 0) begin
        exp_data = exp_q.pop_front();
        was_read = rd_q.pop_front();
        if (was_read) begin
          assert (rdata === exp_data) else begin
            $display("Fail time %0t rdata_o expected %h actual %h", $time, exp_data, rdata);
            data_errs++;
          end
        end
        resp_cnt++;
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
  end

  initial begin : run_end
    wait (stim_done || hung || cycle_cnt >= CYCLE_LIMIT);
    assert (stim_done || hung) else begin
      $display("run stopped at the %0d cycle limit before the tests finished", CYCLE_LIMIT);
      other_errs++;
    end
    $display("errors: %0d data, %0d other, %0d responses seen",
             data_errs, other_errs, resp_cnt);
    if (data_errs == 0 && other_errs == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
dcache_pkg.sv
dcache_tag.sv
dcache_data.sv
dcache_top.sv
mem_ram.sv
mem_subsys_top.sv
tb_clkgen.sv
tb_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= CHECKS FAILED
PASS_MSG  ?= ALL CHECKS PASSED

SRCS := $(wildcard *.sv)
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	@./$(SIM) > $(LOG) 2>&1; echo "simulator exit status $$?" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
